// ==== hw/cam_macros.svh ====
`ifndef CAM_MACROS_SVH
`define CAM_MACROS_SVH

// number of entries in the store
`define CAM_DEPTH 120

// width of one stored entry
`define CAM_DATA_W 128

// the key sits in the low bits of an entry
`define CAM_KEY_W 68

// enough bits to index every entry
`define CAM_LOC_W 7

`endif

// ==== hw/cam_store_pkg.sv ====
`include "cam_macros.svh"

package cam_store_pkg;

  // one stored entry, key in the low bits
  typedef logic [`CAM_DATA_W-1:0] cam_data_t;

  // search key, compared against the low bits of each entry
  typedef logic [`CAM_KEY_W-1:0] cam_key_t;

  // index of an entry in the store
  typedef logic [`CAM_LOC_W-1:0] cam_loc_t;

endpackage

// ==== hw/cam_ctrl_pkg.sv ====
package cam_ctrl_pkg;

  // where the next write location comes from
  typedef enum logic {
    FILL,    // fresh locations remain
    RECYCLE  // only freed locations are used
  } alloc_state_t;

endpackage

// ==== hw/alloc_fsm.sv ====
module alloc_fsm
  import cam_store_pkg::*;
  import cam_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_an,
  input  logic     wvalid,
  input  cam_loc_t fill_loc,
  input  logic     fill_last,
  input  cam_loc_t free_loc,
  input  logic     free_avail,
  output logic     wready,
  output logic     wr_en,
  output logic     fill_step,
  output logic     pop,
  output cam_loc_t wr_loc
);

  alloc_state_t state;

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      state <= FILL;
    end else if (fill_step && fill_last) begin
      state <= RECYCLE; // every location has now been handed out once
    end
  end

  // the store is never full while fresh locations remain
  assign wready = (state == FILL) || free_avail;

  assign wr_en = wvalid && wready;

  assign fill_step = wr_en && (state == FILL);
  assign pop = wr_en && (state == RECYCLE); // consume the oldest freed location

  assign wr_loc = (state == FILL) ? fill_loc : free_loc;

  // once every location went out, the fill counter stays on the last one
  a_recycle_holds_last: assert property (
    @(posedge clk) disable iff (!rst_an)
    (state == RECYCLE) |-> fill_last
  );

endmodule

// ==== hw/fill_counter.sv ====
`include "cam_macros.svh"

module fill_counter
  import cam_store_pkg::*;
(
  input  logic     clk,
  input  logic     rst_an,
  input  logic     fill_step,
  output cam_loc_t fill_loc,
  output logic     fill_last
);

  logic fill_done; // set once the last location has been handed out

  assign fill_last = (fill_loc == cam_loc_t'(`CAM_DEPTH - 1));

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      fill_loc  <= '0;
      fill_done <= 1'b0;
    end else if (fill_step) begin
      if (fill_last) begin
        fill_done <= 1'b1; // counter holds at the top value
      end else begin
        fill_loc <= fill_loc + 1'b1;
      end
    end
  end

  // after the last location went out, the allocator must not ask again
  a_no_step_past_last: assert property (
    @(posedge clk) disable iff (!rst_an)
    fill_done |-> !fill_step
  );

endmodule

// ==== hw/free_list_fifo.sv ====
`include "cam_macros.svh"

module free_list_fifo
  import cam_store_pkg::*;
(
  input  logic     clk,
  input  logic     rst_an,
  input  logic     push,
  input  cam_loc_t push_loc,
  input  logic     pop,
  output cam_loc_t free_loc,
  output logic     free_avail
);

  cam_loc_t mem [`CAM_DEPTH];
  cam_loc_t wr_ptr;
  cam_loc_t rd_ptr;
  logic [`CAM_LOC_W-1:0] count; // 120 still fits in the location width
  logic full;

  assign full = (count == `CAM_LOC_W'(`CAM_DEPTH));
  assign free_avail = (count != '0);
  assign free_loc = mem[rd_ptr]; // head is visible without a read strobe

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_loc;
    end
  end

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == cam_loc_t'(`CAM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == cam_loc_t'(`CAM_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a location is freed at most once per allocation, so the list cannot overflow
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_an)
    push |-> !full
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_an)
    pop |-> free_avail
  );

endmodule

// ==== hw/cam_array.sv ====
`include "cam_macros.svh"

module cam_array
  import cam_store_pkg::*;
(
  input  logic      clk,
  input  logic      rst_an,
  input  logic      wr_en,
  input  cam_loc_t  wr_loc,
  input  cam_data_t wdata,
  input  logic      svalid,
  input  cam_key_t  skey,
  output logic      smatch,
  output cam_data_t sdata,
  output cam_loc_t  hit_loc
);

  cam_data_t mem [`CAM_DEPTH];
  logic [`CAM_DEPTH-1:0] valid;
  logic [`CAM_DEPTH-1:0] hit_vec;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_loc] <= wdata;
    end
  end

  // a write never lands on a valid entry and a hit is always valid, so no clash
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      valid <= '0;
    end else begin
      if (wr_en) begin
        valid[wr_loc] <= 1'b1;
      end
      if (smatch) begin
        valid[hit_loc] <= 1'b0; // freed entry stops matching from the next cycle
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      hit_vec[i] = svalid && valid[i] && (mem[i][`CAM_KEY_W-1:0] == skey);
    end
  end

  // walk down from the top so the lowest matching index wins
  always_comb begin
    smatch  = 1'b0;
    hit_loc = '0;
    for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        smatch  = 1'b1;
        hit_loc = cam_loc_t'(i);
      end
    end
  end

  assign sdata = smatch ? mem[hit_loc] : '0;

  // the allocator only hands out locations that are empty
  a_write_to_free_loc: assert property (
    @(posedge clk) disable iff (!rst_an)
    wr_en |-> !valid[wr_loc]
  );

endmodule

// ==== hw/cam_top.sv ====
`include "cam_macros.svh"

module cam_top (
  input  logic                  clk,
  input  logic                  rst_an,
  input  logic [`CAM_DATA_W-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic                  svalid,
  input  logic [`CAM_KEY_W-1:0] skey,
  output logic                  smatch,
  output logic [`CAM_DATA_W-1:0] sdata
);

  logic                 wr_en;
  logic [`CAM_LOC_W-1:0] wr_loc;
  logic                 fill_step;
  logic [`CAM_LOC_W-1:0] fill_loc;
  logic                 fill_last;
  logic                 pop;
  logic [`CAM_LOC_W-1:0] free_loc;
  logic                 free_avail;
  logic [`CAM_LOC_W-1:0] hit_loc;

  alloc_fsm u_alloc_fsm (
    .clk        (clk),
    .rst_an     (rst_an),
    .wvalid     (wvalid),
    .fill_loc   (fill_loc),
    .fill_last  (fill_last),
    .free_loc   (free_loc),
    .free_avail (free_avail),
    .wready     (wready),
    .wr_en      (wr_en),
    .fill_step  (fill_step),
    .pop        (pop),
    .wr_loc     (wr_loc)
  );

  fill_counter u_fill_counter (
    .clk       (clk),
    .rst_an    (rst_an),
    .fill_step (fill_step),
    .fill_loc  (fill_loc),
    .fill_last (fill_last)
  );

  // every hit hands its location back for reuse
  free_list_fifo u_free_list_fifo (
    .clk        (clk),
    .rst_an     (rst_an),
    .push       (smatch),
    .push_loc   (hit_loc),
    .pop        (pop),
    .free_loc   (free_loc),
    .free_avail (free_avail)
  );

  cam_array u_cam_array (
    .clk     (clk),
    .rst_an  (rst_an),
    .wr_en   (wr_en),
    .wr_loc  (wr_loc),
    .wdata   (wdata),
    .svalid  (svalid),
    .skey    (skey),
    .smatch  (smatch),
    .sdata   (sdata),
    .hit_loc (hit_loc)
  );

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_an
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_an = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_an = 1'b1; // released in step with the stimulus offset
  end

endmodule

// ==== tests/cam_checker.sv ====
`include "cam_macros.svh"

module cam_checker
  import cam_store_pkg::*;
(
  input  logic      clk,
  input  logic      rst_an,
  input  cam_data_t wdata,
  input  logic      wvalid,
  input  logic      wready,
  input  logic      svalid,
  input  cam_key_t  skey,
  input  logic      smatch,
  input  cam_data_t sdata,
  output int        error_count,
  output int        check_count
);
  timeunit 1ns;
  timeprecision 100ps;

  cam_data_t m_data [`CAM_DEPTH];
  logic      m_valid [`CAM_DEPTH];
  int        m_next_fill;
  logic      m_recycle; // every location has been handed out once
  int        m_free_q [$];

  logic      exp_ready;
  logic      exp_match;
  cam_data_t exp_data;
  int        exp_loc;
  int        wr_loc;
  int        errors = 0;
  int        checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  // lowest valid location whose low key bits equal the key
  function automatic logic ref_search(input cam_key_t key, output cam_data_t data,
                                      output int loc);
    data = '0;
    loc  = -1;
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      if (m_valid[i] && (m_data[i][`CAM_KEY_W-1:0] == key)) begin
        data = m_data[i];
        loc  = i;
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic ref_wready();
    return !m_recycle || (m_free_q.size() > 0);
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_data[i]  = '0;
    end
    m_next_fill = 0;
    m_recycle   = 1'b0;
    m_free_q.delete();
  endtask

  task automatic report_mismatch(input string name, input cam_data_t exp, input cam_data_t got);
    errors++;
    $display("MISMATCH %s at %0t: expected 0x%0h, got 0x%0h", name, $time, exp, got);
  endtask

  // outputs are settled at the falling edge, inputs change only after the rising edge
  always @(negedge clk) begin
    if (!rst_an) begin
      reset_model();
    end else begin
      exp_ready = ref_wready();
      exp_match = 1'b0;
      checks++;
      if (wready !== exp_ready) begin
        report_mismatch("wready", cam_data_t'(exp_ready), cam_data_t'(wready));
      end
      if (svalid) begin
        exp_match = ref_search(skey, exp_data, exp_loc);
        checks++;
        if (smatch !== exp_match) begin
          report_mismatch("smatch", cam_data_t'(exp_match), cam_data_t'(smatch));
        end
        if (sdata !== exp_data) begin
          report_mismatch("sdata", exp_data, sdata);
        end
      end
      // the write is placed after the search so the search sees the old contents
      if (wvalid && exp_ready) begin
        if (!m_recycle) begin
          wr_loc = m_next_fill;
          if (m_next_fill == `CAM_DEPTH - 1) begin
            m_recycle = 1'b1;
          end else begin
            m_next_fill++;
          end
        end else begin
          wr_loc = m_free_q.pop_front();
        end
        m_data[wr_loc]  = wdata;
        m_valid[wr_loc] = 1'b1;
      end
      if (exp_match) begin
        m_valid[exp_loc] = 1'b0;
        m_free_q.push_back(exp_loc); // usable from the next cycle on
      end
    end
  end

endmodule

// ==== tests/tb_top.sv ====
`include "cam_macros.svh"

module tb_top
  import cam_store_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_CYCLES  = 16; // a write that should go through
  localparam int HOLD_CYCLES  = 4;  // a write that should be held off
  // fill, search, refill and the smaller tests all fit in four passes over the store
  localparam int NUM_OPS      = 4 * `CAM_DEPTH + 64;
  localparam int TIMEOUT_NS   = NUM_OPS * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

  logic        clk;
  logic        rst_an;
  cam_data_t   wdata;
  logic        wvalid;
  logic        wready;
  logic        svalid;
  cam_key_t    skey;
  logic        smatch;
  cam_data_t   sdata;
  int          error_count;
  int          check_count;
  logic [31:0] lcg_state = 32'h2ef4;
  cam_key_t    keys [256];
  cam_key_t    miss_key;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk    (clk),
    .rst_an (rst_an)
  );

  cam_top UUT (
    .clk    (clk),
    .rst_an (rst_an),
    .wdata  (wdata),
    .wvalid (wvalid),
    .wready (wready),
    .svalid (svalid),
    .skey   (skey),
    .smatch (smatch),
    .sdata  (sdata)
  );

  cam_checker u_checker (
    .clk         (clk),
    .rst_an      (rst_an),
    .wdata       (wdata),
    .wvalid      (wvalid),
    .wready      (wready),
    .svalid      (svalid),
    .skey        (skey),
    .smatch      (smatch),
    .sdata       (sdata),
    .error_count (error_count),
    .check_count (check_count)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // holds wvalid and wdata until wready is seen or the wait runs out
  task automatic offer_write(input cam_data_t data, input int max_cycles);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    wdata    = data;
    wvalid   = 1'b1;
    while (!accepted && waited < max_cycles) begin
      @(negedge clk);
      accepted = wready;
      @(posedge clk);
      #2;
      waited++;
    end
    wvalid = 1'b0;
  endtask

  // the serial sits in the low key bits so fresh keys never collide
  task automatic write_serial(input int serial, input int key_from, input int max_cycles);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    if (key_from == serial) begin
      keys[serial] = {r0, r1[19:0], 16'(serial)};
    end else begin
      keys[serial] = keys[key_from];
    end
    offer_write({r2, r3[27:0], keys[serial]}, max_cycles);
  endtask

  task automatic search_key(input cam_key_t key);
    svalid = 1'b1;
    skey   = key;
    @(posedge clk);
    #2;
    svalid = 1'b0;
  endtask

  initial begin
    wdata  = '0;
    wvalid = 1'b0;
    svalid = 1'b0;
    skey   = '0;
    @(posedge rst_an);

    for (int i = 0; i < `CAM_DEPTH; i++) begin
      write_serial(i, i, WAIT_CYCLES);
    end
    write_serial(250, 250, HOLD_CYCLES); // store full, nothing freed yet

    // stride 7 visits every location and frees them out of order
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      search_key(keys[(i * 7) % `CAM_DEPTH]);
    end
    for (int i = 0; i < 4; i++) begin
      miss_key = {next_rand(), 20'hfffff, 16'hf000 + 16'(i)};
      search_key(miss_key);
    end
    for (int i = 0; i < 10; i++) begin
      search_key(keys[i]); // already freed, must miss
    end

    for (int i = 0; i < `CAM_DEPTH; i++) begin
      write_serial(`CAM_DEPTH + i, `CAM_DEPTH + i, WAIT_CYCLES);
    end
    write_serial(251, 251, HOLD_CYCLES);

    for (int i = 0; i < 5; i++) begin
      search_key(keys[`CAM_DEPTH + i * 13]);
    end
    for (int i = 240; i < 245; i++) begin
      write_serial(i, i, WAIT_CYCLES);
    end
    write_serial(252, 252, HOLD_CYCLES); // exactly five went in
    for (int i = 240; i < 245; i++) begin
      search_key(keys[i]);
    end

    // equal keys in two freed locations, lower location answers first
    write_serial(245, 245, WAIT_CYCLES);
    write_serial(246, 245, WAIT_CYCLES);
    repeat (3) search_key(keys[245]);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Test completed successfully");
    end else begin
      if (check_count == 0) begin
        $display("no outputs were checked during the run");
      end
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("the run timed out after %0d ns before the tests finished", TIMEOUT_NS);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/cam_store_pkg.sv
hw/cam_ctrl_pkg.sv
hw/alloc_fsm.sv
hw/fill_counter.sv
hw/free_list_fifo.sv
hw/cam_array.sv
hw/cam_top.sv
tests/tb_clock.sv
tests/cam_checker.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
